//--- verilog.f
hw/pmu_pkg.sv
hw/pmu_i2c_if.sv
hw/frame_header_decoder.sv
hw/pmu_setting_regs.sv
hw/pmu_cmd_ctrl.sv
hw/pmu_i2c_master.sv
hw/reply_framer.sv
hw/pmu_int.sv
verif/pmu_i2c_model.sv
verif/tb_pmu_int.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_pmu_int -f verilog.f -o tb_pmu_int

out=$(./obj_dir/tb_pmu_int)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1

//--- verif/tb_pmu_int.sv
`default_nettype none

module tb_pmu_int;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_ROWS = 20;
	localparam int REPLY_TIMEOUT = 2000; // cycles
	localparam int IDLE_TIMEOUT = 400;

	logic clk;
	logic reset;
	logic in_frame_valid;
	logic in_data_valid;
	logic [7:0] in_data;
	logic force_nak;
	logic out_frame_valid;
	logic out_data_valid;
	logic [7:0] out_data;
	logic [7:0] debug;
	wire pmu_scl;
	wire pmu_sda;

	// command table
	logic [7:0] frame_bytes [0:MAX_ROWS-1][0:4];
	int frame_len [0:MAX_ROWS-1];
	logic nak_flag [0:MAX_ROWS-1];
	logic [7:0] exp_bytes [0:MAX_ROWS-1][0:3];
	int exp_len [0:MAX_ROWS-1];
	logic reg_chk [0:MAX_ROWS-1];
	logic [7:0] reg_addr [0:MAX_ROWS-1];
	logic [7:0] reg_val [0:MAX_ROWS-1];
	int n_rows;

	logic [3:0] en_shadow; // expected chip enable bits
	logic [4:0] volt_shadow [0:3];
	logic [7:0] rx [$];
	int error_cnt;
	int timeout_cnt;

	pullup (pmu_scl);
	pullup (pmu_sda);

	pmu_int pmu_int_inst (
		.clk(clk), .reset(reset),
		.in_frame_valid(in_frame_valid), .in_data_valid(in_data_valid), .in_data(in_data),
		.pmu_scl(pmu_scl), .pmu_sda(pmu_sda),
		.out_frame_valid(out_frame_valid), .out_data_valid(out_data_valid),
		.out_data(out_data), .debug(debug)
	);

	pmu_i2c_model pmu_model (
		.clk(clk), .scl(pmu_scl), .sda(pmu_sda), .force_nak(force_nak)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [7:0] volt_addr(input logic [1:0] idx);
		case (idx)
			2'd0: return pmu_pkg::VOLT_SUBADDR_0;
			2'd1: return pmu_pkg::VOLT_SUBADDR_1;
			2'd2: return pmu_pkg::VOLT_SUBADDR_2;
			default: return pmu_pkg::VOLT_SUBADDR_3;
		endcase
	endfunction

	// chip layout of the enable register
	function automatic logic [7:0] en_map(input logic [3:0] en);
		return {3'b100, en[0], 1'b1, en[2], en[1], en[3]};
	endfunction

	function automatic logic en_bit(input logic [7:0] value, input logic [1:0] idx);
		case (idx)
			2'd0: return value[4];
			2'd1: return value[1];
			2'd2: return value[2];
			default: return value[0];
		endcase
	endfunction

	task automatic add_set(input logic [7:0] eid, input logic [7:0] param,
		input logic [1:0] idx, input logic [7:0] value, input logic nak);
		int r;
		r = n_rows;
		frame_bytes[r][0] = pmu_pkg::SET_ADDR;
		frame_bytes[r][1] = eid;
		frame_bytes[r][2] = param;
		frame_bytes[r][3] = {6'd0, idx};
		frame_bytes[r][4] = value;
		frame_len[r] = 5;
		nak_flag[r] = nak;
		exp_bytes[r][0] = {7'd0, nak};
		exp_bytes[r][1] = eid;
		exp_bytes[r][2] = 8'h00;
		exp_bytes[r][3] = 8'h00;
		exp_len[r] = 3;
		reg_chk[r] = 1'b1;
		if (param == pmu_pkg::PARAM_VOLT) begin
			if (!nak)
				volt_shadow[idx] = value[4:0];
			reg_addr[r] = volt_addr(idx);
			reg_val[r] = {3'b000, volt_shadow[idx]};
		end else begin
			if (!nak)
				en_shadow[idx] = value[0];
			reg_addr[r] = pmu_pkg::EN_SUBADDR;
			reg_val[r] = en_map(en_shadow);
		end
		n_rows++;
	endtask

	task automatic add_query(input logic [7:0] eid, input logic [7:0] param,
		input logic [1:0] idx, input logic nak);
		int r;
		r = n_rows;
		frame_bytes[r][0] = pmu_pkg::QUERY_ADDR;
		frame_bytes[r][1] = eid;
		frame_bytes[r][2] = param;
		frame_bytes[r][3] = {6'd0, idx};
		frame_bytes[r][4] = 8'h00;
		frame_len[r] = 4;
		nak_flag[r] = nak;
		exp_bytes[r][0] = {7'd0, nak};
		exp_bytes[r][1] = eid;
		exp_bytes[r][2] = 8'h01; // size
		if (nak)
			exp_bytes[r][3] = 8'h00;
		else if (param == pmu_pkg::PARAM_VOLT)
			exp_bytes[r][3] = {3'b000, volt_shadow[idx]};
		else
			exp_bytes[r][3] = {7'd0, en_bit(en_map(en_shadow), idx)};
		exp_len[r] = 4;
		reg_chk[r] = 1'b0;
		reg_addr[r] = 8'h00;
		reg_val[r] = 8'h00;
		n_rows++;
	endtask

	task automatic add_foreign(input logic [7:0] addr, input logic [7:0] eid);
		int r;
		r = n_rows;
		frame_bytes[r][0] = addr;
		frame_bytes[r][1] = eid;
		frame_bytes[r][2] = pmu_pkg::PARAM_VOLT;
		frame_bytes[r][3] = 8'h01;
		frame_bytes[r][4] = 8'h00;
		frame_len[r] = 4;
		nak_flag[r] = 1'b0;
		exp_len[r] = 0; // no reply at all
		reg_chk[r] = 1'b0;
		reg_addr[r] = 8'h00;
		reg_val[r] = 8'h00;
		n_rows++;
	endtask

	task automatic build_table();
		en_shadow = 4'd0;
		for (int i = 0; i < 4; i++)
			volt_shadow[i] = 5'd0;
		add_set(8'h11, 8'h65, 2'd2, 8'h01, 1'b0); // 'e' selects enable
		add_set(8'h20, pmu_pkg::PARAM_VOLT, 2'd0, 8'hea, 1'b0); // upper bits dropped
		add_set(8'h21, pmu_pkg::PARAM_VOLT, 2'd1, 8'h15, 1'b0);
		add_set(8'h22, pmu_pkg::PARAM_VOLT, 2'd2, 8'h3f, 1'b0);
		add_set(8'h23, pmu_pkg::PARAM_VOLT, 2'd3, 8'h03, 1'b0);
		for (int i = 0; i < 4; i++)
			add_query(8'h30 + 8'(i), pmu_pkg::PARAM_VOLT, 2'(i), 1'b0);
		for (int i = 0; i < 4; i++)
			add_query(8'h38 + 8'(i), 8'h65, 2'(i), 1'b0);
		add_set(8'h40, pmu_pkg::PARAM_VOLT, 2'd1, 8'h11, 1'b1);
		add_query(8'h41, pmu_pkg::PARAM_VOLT, 2'd2, 1'b1);
		add_foreign(8'h33, 8'h42);
		add_set(8'h43, pmu_pkg::PARAM_VOLT, 2'd3, 8'h07, 1'b0);
	endtask

	task automatic check_status(input string name, input pmu_pkg::reply_status_t got,
		input pmu_pkg::reply_status_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			error_cnt++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			error_cnt++;
		end
	endtask

	task automatic check_len(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			error_cnt++;
		end
	endtask

	task automatic send_frame(input int r);
		@(posedge clk);
		#5;
		in_frame_valid = 1'b1;
		for (int i = 0; i < frame_len[r]; i++) begin
			in_data = frame_bytes[r][i];
			in_data_valid = 1'b1;
			@(posedge clk);
			#5;
			in_data_valid = 1'b0;
			@(posedge clk); // one idle cycle between bytes
			#5;
		end
		in_frame_valid = 1'b0;
	endtask

	task automatic collect_reply(input int r);
		int waited;
		rx.delete();
		waited = 0;
		@(negedge clk);
		while (out_frame_valid !== 1'b1 && waited < REPLY_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (out_frame_valid !== 1'b1) begin
			if (exp_len[r] != 0) begin
				$display("row %0d: no reply frame before the timeout", r);
				timeout_cnt++;
			end
			return;
		end
		waited = 0;
		while (out_frame_valid === 1'b1 && waited < 8) begin
			if (out_data_valid === 1'b1)
				rx.push_back(out_data);
			@(negedge clk);
			waited++;
		end
		if (out_frame_valid === 1'b1) begin
			$display("row %0d: reply frame did not end", r);
			timeout_cnt++;
		end
		check_len($sformatf("row %0d reply length", r), rx.size(), exp_len[r]);
		if (rx.size() == exp_len[r] && exp_len[r] > 0) begin
			check_status($sformatf("row %0d reply status", r),
				pmu_pkg::reply_status_t'(rx[0]), pmu_pkg::reply_status_t'(exp_bytes[r][0]));
			for (int i = 1; i < exp_len[r]; i++)
				check_byte($sformatf("row %0d reply byte %0d", r, i), rx[i], exp_bytes[r][i]);
		end
	endtask

	// bus released and controller back in idle
	task automatic wait_bus_idle();
		int waited;
		int quiet;
		waited = 0;
		quiet = 0;
		while (quiet < 20 && waited < IDLE_TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (pmu_scl === 1'b1 && pmu_sda === 1'b1 &&
				pmu_pkg::ctrl_state_t'(debug[4:0]) == pmu_pkg::ST_IDLE)
				quiet++;
			else
				quiet = 0;
		end
		if (quiet < 20) begin
			$display("the I2C bus and the controller did not return to idle in time");
			timeout_cnt++;
		end
	endtask

	initial begin
		reset = 1'b1;
		in_frame_valid = 1'b0;
		in_data_valid = 1'b0;
		in_data = 8'h00;
		force_nak = 1'b0;
		error_cnt = 0;
		timeout_cnt = 0;
		n_rows = 0;
		build_table();
		repeat (4) @(posedge clk);
		#5;
		reset = 1'b0;
		wait_bus_idle();
		for (int r = 0; r < n_rows; r++) begin
			force_nak = nak_flag[r]; // model withholds the address ack
			send_frame(r);
			collect_reply(r);
			if (reg_chk[r])
				check_byte($sformatf("row %0d pmu reg 0x%h", r, reg_addr[r]),
					pmu_model.regs[reg_addr[r]], reg_val[r]);
			wait_bus_idle();
		end
		$display("errors: %0d, timeouts: %0d", error_cnt, timeout_cnt);
		if (error_cnt == 0 && timeout_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end
endmodule

`default_nettype wire

//--- verif/pmu_i2c_model.sv
`default_nettype none

module pmu_i2c_model (
	input wire logic clk,
	input wire logic scl,
	inout wire sda,
	input wire logic force_nak
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] regs [0:255];
	logic scl_q;
	logic sda_q;
	logic active; // addressed, inside a transfer
	logic first_byte;
	logic have_ptr; // register address already received
	logic rw_mode; // 1 read
	logic sending;
	logic master_ack;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic [7:0] tx;
	logic [7:0] ptr;
	logic sda_low;

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial begin
		for (int i = 0; i < 256; i++)
			regs[i] = 8'(i) ^ 8'ha5;
		scl_q = 1'b1;
		sda_q = 1'b1;
		active = 1'b0;
		first_byte = 1'b0;
		have_ptr = 1'b0;
		rw_mode = 1'b0;
		sending = 1'b0;
		master_ack = 1'b0;
		bit_cnt = 4'd0;
		shreg = 8'h00;
		tx = 8'h00;
		ptr = 8'h00;
		sda_low = 1'b0;
	end

	// oversampled with the system clock
	always @(posedge clk) begin
		scl_q <= scl;
		sda_q <= sda;
		if (scl && scl_q && sda_q && !sda) begin // start or repeated start
			active <= 1'b1;
			first_byte <= 1'b1;
			have_ptr <= 1'b0;
			rw_mode <= 1'b0;
			sending <= 1'b0;
			bit_cnt <= 4'hf; // scl fall after the start wraps to 0
			sda_low <= 1'b0;
		end else if (scl && scl_q && !sda_q && sda) begin // stop
			active <= 1'b0;
			sending <= 1'b0;
			sda_low <= 1'b0;
		end else if (active && scl && !scl_q) begin
			if (bit_cnt == 4'd8)
				master_ack <= !sda;
			else
				shreg <= {shreg[6:0], sda};
		end else if (active && !scl && scl_q) begin
			if (bit_cnt == 4'd7) begin
				bit_cnt <= 4'd8;
				sda_low <= 1'b0;
				if (!sending && first_byte) begin
					first_byte <= 1'b0;
					if (shreg[7:1] == 7'h34 && !force_nak) begin
						sda_low <= 1'b1;
						rw_mode <= shreg[0];
					end else
						active <= 1'b0; // no ack, master gives up
				end else if (!sending) begin
					sda_low <= 1'b1;
					if (!have_ptr) begin
						ptr <= shreg;
						have_ptr <= 1'b1;
					end else begin
						regs[ptr] <= shreg;
						ptr <= ptr + 8'd1;
					end
				end
			end else if (bit_cnt == 4'd8) begin
				bit_cnt <= 4'd0;
				if (rw_mode && (!sending || master_ack)) begin
					sending <= 1'b1;
					tx <= regs[ptr];
					ptr <= ptr + 8'd1;
					sda_low <= !regs[ptr][7];
				end else begin
					sending <= 1'b0;
					sda_low <= 1'b0;
				end
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
				if (sending)
					sda_low <= !tx[3'd6 - bit_cnt[2:0]];
			end
		end
	end
endmodule

`default_nettype wire

//--- hw/pmu_int.sv
`default_nettype none

module pmu_int (
	input wire logic clk,
	input wire logic reset,
	input wire logic in_frame_valid,
	input wire logic in_data_valid,
	input wire logic [7:0] in_data,
	inout wire pmu_scl,
	inout wire pmu_sda,
	output wire logic out_frame_valid,
	output wire logic out_data_valid,
	output wire logic [7:0] out_data,
	output wire logic [7:0] debug
);
	logic header_done_clear;
	logic set_done;
	logic [7:0] set_eid;
	logic set_arg_valid;
	logic [7:0] set_arg_data;
	logic qry_done;
	logic [7:0] qry_eid;
	logic qry_arg_valid;
	logic [7:0] qry_arg_data;
	logic latch_param;
	logic latch_idx;
	logic latch_val;
	logic [7:0] subaddr;
	logic [7:0] wvalue;
	logic is_volt;
	logic [1:0] rail_idx;
	logic ack_req;
	logic nak_req;
	logic query_req;
	logic [7:0] reply_eid;
	logic [7:0] reply_data;
	pmu_pkg::ctrl_state_t ctrl_state;

	pmu_i2c_if i2c_bus ();

	assign debug = {3'b000, ctrl_state};

	frame_header_decoder #(.match_addr(pmu_pkg::SET_ADDR)) set_dec (
		.clk(clk), .reset(reset),
		.in_frame_valid(in_frame_valid), .in_data_valid(in_data_valid), .in_data(in_data),
		.header_done_clear(header_done_clear),
		.header_done(set_done), .header_eid(set_eid),
		.arg_valid(set_arg_valid), .arg_data(set_arg_data)
	);

	frame_header_decoder #(.match_addr(pmu_pkg::QUERY_ADDR)) qry_dec (
		.clk(clk), .reset(reset),
		.in_frame_valid(in_frame_valid), .in_data_valid(in_data_valid), .in_data(in_data),
		.header_done_clear(header_done_clear),
		.header_done(qry_done), .header_eid(qry_eid),
		.arg_valid(qry_arg_valid), .arg_data(qry_arg_data)
	);

	// both decoders register the same input byte
	pmu_setting_regs regs (
		.clk(clk), .reset(reset),
		.latch_param(latch_param), .latch_idx(latch_idx), .latch_val(latch_val),
		.arg_data(set_arg_data),
		.subaddr(subaddr), .wvalue(wvalue), .is_volt(is_volt), .rail_idx(rail_idx)
	);

	pmu_cmd_ctrl ctrl (
		.clk(clk), .reset(reset),
		.set_done(set_done), .set_eid(set_eid),
		.set_arg_valid(set_arg_valid), .set_arg_data(set_arg_data),
		.qry_done(qry_done), .qry_eid(qry_eid),
		.qry_arg_valid(qry_arg_valid), .qry_arg_data(qry_arg_data),
		.header_done_clear(header_done_clear),
		.latch_param(latch_param), .latch_idx(latch_idx), .latch_val(latch_val),
		.subaddr(subaddr), .wvalue(wvalue), .is_volt(is_volt), .rail_idx(rail_idx),
		.i2c(i2c_bus),
		.ack_req(ack_req), .nak_req(nak_req), .query_req(query_req),
		.reply_eid(reply_eid), .reply_data(reply_data),
		.state(ctrl_state)
	);

	pmu_i2c_master i2c_master (
		.clk(clk), .reset(reset),
		.i2c(i2c_bus), .clear_failed(i2c_bus.clear_failed),
		.scl(pmu_scl), .sda(pmu_sda)
	);

	reply_framer framer (
		.clk(clk), .reset(reset),
		.ack_req(ack_req), .nak_req(nak_req), .query_req(query_req),
		.reply_eid(reply_eid), .reply_data(reply_data),
		.out_frame_valid(out_frame_valid), .out_data_valid(out_data_valid),
		.out_data(out_data)
	);
endmodule

`default_nettype wire

//--- hw/reply_framer.sv
`default_nettype none

module reply_framer (
	input wire logic clk,
	input wire logic reset,
	input wire logic ack_req,
	input wire logic nak_req,
	input wire logic query_req,
	input wire logic [7:0] reply_eid,
	input wire logic [7:0] reply_data,
	output logic out_frame_valid,
	output logic out_data_valid,
	output logic [7:0] out_data
);
	pmu_pkg::reply_status_t status_q;
	logic [7:0] eid_q;
	logic [7:0] data_q;
	logic is_query; // query replies carry one data byte
	logic active;
	logic [1:0] idx;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			idx <= 2'd0;
			is_query <= 1'b0;
		end else if (ack_req || nak_req) begin
			active <= 1'b1;
			idx <= 2'd0;
			is_query <= query_req;
		end else if (active) begin
			idx <= idx + 2'd1;
			if (idx == (is_query ? 2'd3 : 2'd2))
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ack_req || nak_req) begin
			status_q <= nak_req ? pmu_pkg::STATUS_NAK : pmu_pkg::STATUS_ACK;
			eid_q <= reply_eid;
			data_q <= reply_data;
		end
	end

	assign out_frame_valid = active;
	assign out_data_valid = active;

	always_comb begin
		case (idx)
			2'd0: out_data = status_q;
			2'd1: out_data = eid_q;
			2'd2: out_data = {7'd0, is_query}; // size
			default: out_data = data_q;
		endcase
	end
endmodule

`default_nettype wire

//--- hw/pmu_i2c_master.sv
`default_nettype none

module pmu_i2c_master (
	input wire logic clk,
	input wire logic reset,
	pmu_i2c_if.master i2c,
	input wire logic clear_failed,
	inout wire scl,
	inout wire sda
);
	typedef enum logic [2:0] {M_IDLE, M_START, M_BIT, M_HOLD, M_STOP} mstate_t;

	mstate_t mstate;
	logic [15:0] div_cnt;
	logic tick;
	logic [1:0] qcnt; // quarter within a bit
	logic [3:0] bit_cnt; // 8 is the ack slot
	logic [7:0] shreg;
	logic reading;
	logic scl_low;
	logic sda_low;

	// open drain, only pull low or release
	assign scl = scl_low ? 1'b0 : 1'bz;
	assign sda = sda_low ? 1'b0 : 1'bz;
	assign tick = (div_cnt == pmu_pkg::I2C_QUARTER - 16'd1);

	always_ff @(posedge clk) begin
		if (reset || tick)
			div_cnt <= 16'd0;
		else
			div_cnt <= div_cnt + 16'd1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mstate <= M_IDLE;
			qcnt <= 2'd0;
			bit_cnt <= 4'd0;
			reading <= 1'b0;
			scl_low <= 1'b0;
			sda_low <= 1'b0;
			i2c.data_latched <= 1'b0;
			i2c.ready <= 1'b0;
			i2c.rdata_valid <= 1'b0;
			i2c.failed <= 1'b0;
		end else begin
			i2c.data_latched <= 1'b0;
			i2c.ready <= 1'b0;
			i2c.rdata_valid <= 1'b0;
			if (clear_failed)
				i2c.failed <= 1'b0;
			if (tick) begin
				case (mstate)
					M_IDLE: begin
						if (i2c.start)
							mstate <= M_START;
					end
					M_START: begin // also the repeated start from hold
						qcnt <= qcnt + 2'd1;
						if (qcnt == 2'd0)
							sda_low <= 1'b0;
						else if (qcnt == 2'd1)
							scl_low <= 1'b0;
						else if (qcnt == 2'd2)
							sda_low <= 1'b1; // sda falls with scl high
						else begin
							scl_low <= 1'b1;
							shreg <= i2c.wdata;
							reading <= 1'b0; // address byte is always written
							bit_cnt <= 4'd0;
							i2c.data_latched <= 1'b1;
							mstate <= M_BIT;
						end
					end
					M_BIT: begin
						qcnt <= qcnt + 2'd1;
						if (qcnt == 2'd0)
							sda_low <= (bit_cnt != 4'd8) && !reading && !shreg[7];
						else if (qcnt == 2'd1)
							scl_low <= 1'b0;
						else if (qcnt == 2'd3) begin
							scl_low <= 1'b1;
							if (bit_cnt != 4'd8) begin
								shreg <= {shreg[6:0], sda};
								bit_cnt <= bit_cnt + 4'd1;
							end else if (!reading && sda) begin
								i2c.failed <= 1'b1; // no ack, straight to stop
								mstate <= M_STOP;
							end else begin
								i2c.rdata <= shreg;
								i2c.rdata_valid <= reading;
								if (i2c.done) begin
									i2c.ready <= 1'b1;
									mstate <= M_HOLD;
								end else begin
									shreg <= i2c.wdata;
									reading <= !i2c.rw;
									bit_cnt <= 4'd0;
									i2c.data_latched <= 1'b1;
								end
							end
						end
					end
					M_HOLD: begin // scl held low, controller decides
						if (i2c.start)
							mstate <= M_START;
						else
							mstate <= M_STOP;
					end
					default: begin
						qcnt <= qcnt + 2'd1;
						if (qcnt == 2'd0)
							sda_low <= 1'b1;
						else if (qcnt == 2'd1)
							scl_low <= 1'b0;
						else if (qcnt == 2'd2)
							sda_low <= 1'b0; // stop condition
						else
							mstate <= M_IDLE;
					end
				endcase
			end
		end
	end
endmodule

`default_nettype wire

//--- hw/pmu_cmd_ctrl.sv
`default_nettype none

module pmu_cmd_ctrl (
	input wire logic clk,
	input wire logic reset,
	input wire logic set_done,
	input wire logic [7:0] set_eid,
	input wire logic set_arg_valid,
	input wire logic [7:0] set_arg_data,
	input wire logic qry_done,
	input wire logic [7:0] qry_eid,
	input wire logic qry_arg_valid,
	input wire logic [7:0] qry_arg_data,
	output logic header_done_clear,
	output logic latch_param,
	output logic latch_idx,
	output logic latch_val,
	input wire logic [7:0] subaddr,
	input wire logic [7:0] wvalue,
	input wire logic is_volt,
	input wire logic [1:0] rail_idx,
	pmu_i2c_if.ctrl i2c,
	output logic ack_req,
	output logic nak_req,
	output logic query_req,
	output logic [7:0] reply_eid,
	output logic [7:0] reply_data,
	output pmu_pkg::ctrl_state_t state
);
	logic [7:0] rd_byte;
	logic en_bit;
	logic replying;

	assign header_done_clear = (state == pmu_pkg::ST_IDLE) && (set_done || qry_done);
	assign latch_param = (state == pmu_pkg::ST_GET_PARAM && set_arg_valid) ||
		(state == pmu_pkg::ST_RD_GET_PARAM && qry_arg_valid);
	assign latch_idx = (state == pmu_pkg::ST_GET_IDX && set_arg_valid) ||
		(state == pmu_pkg::ST_RD_GET_IDX && qry_arg_valid);
	assign latch_val = (state == pmu_pkg::ST_GET_VAL) && set_arg_valid;

	assign i2c.clear_failed = (state == pmu_pkg::ST_IDLE);
	assign i2c.start = (state == pmu_pkg::ST_I2C_ADDR) || (state == pmu_pkg::ST_RD_WR_ADDR) ||
		(state == pmu_pkg::ST_RD_RD_ADDR);
	assign i2c.done = (state == pmu_pkg::ST_I2C_DONE) || (state == pmu_pkg::ST_RD_WR_DONE) ||
		(state == pmu_pkg::ST_RD_DONE);
	assign i2c.rw = !((state == pmu_pkg::ST_RD_DATA) || (state == pmu_pkg::ST_RD_DONE));

	always_comb begin
		case (state)
			pmu_pkg::ST_I2C_ADDR, pmu_pkg::ST_RD_WR_ADDR: i2c.wdata = pmu_pkg::PMU_WR_ADDR;
			pmu_pkg::ST_RD_RD_ADDR: i2c.wdata = pmu_pkg::PMU_RD_ADDR;
			pmu_pkg::ST_I2C_SUBADDR, pmu_pkg::ST_RD_SUBADDR: i2c.wdata = subaddr;
			default: i2c.wdata = wvalue;
		endcase
	end

	// enable bit order of the chip register
	always_comb begin
		case (rail_idx)
			2'd0: en_bit = rd_byte[4];
			2'd1: en_bit = rd_byte[1];
			2'd2: en_bit = rd_byte[2];
			default: en_bit = rd_byte[0];
		endcase
	end

	assign replying = (state == pmu_pkg::ST_ACK) || (state == pmu_pkg::ST_RD_REPLY);
	assign ack_req = replying && !i2c.failed;
	assign nak_req = replying && i2c.failed;
	assign query_req = (state == pmu_pkg::ST_RD_REPLY);
	assign reply_data = i2c.failed ? 8'h00 : (is_volt ? rd_byte : {7'd0, en_bit});

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pmu_pkg::ST_IDLE;
			reply_eid <= 8'h00;
			rd_byte <= 8'h00;
		end else begin
			if (i2c.rdata_valid)
				rd_byte <= i2c.rdata;
			case (state)
				pmu_pkg::ST_IDLE: begin
					if (set_done) begin
						reply_eid <= set_eid;
						state <= pmu_pkg::ST_GET_PARAM;
					end else if (qry_done) begin
						reply_eid <= qry_eid;
						state <= pmu_pkg::ST_RD_GET_PARAM;
					end
				end
				pmu_pkg::ST_GET_PARAM: if (set_arg_valid) state <= pmu_pkg::ST_GET_IDX;
				pmu_pkg::ST_GET_IDX: if (set_arg_valid) state <= pmu_pkg::ST_GET_VAL;
				pmu_pkg::ST_GET_VAL: if (set_arg_valid) state <= pmu_pkg::ST_I2C_ADDR;
				pmu_pkg::ST_I2C_ADDR, pmu_pkg::ST_I2C_SUBADDR, pmu_pkg::ST_I2C_DATA: begin
					if (i2c.failed)
						state <= pmu_pkg::ST_ACK; // nak reply
					else if (i2c.data_latched)
						state <= pmu_pkg::ctrl_state_t'(state + 5'd1);
				end
				pmu_pkg::ST_I2C_DONE: begin
					if (i2c.failed || i2c.ready)
						state <= pmu_pkg::ST_ACK;
				end
				pmu_pkg::ST_RD_GET_PARAM: if (qry_arg_valid) state <= pmu_pkg::ST_RD_GET_IDX;
				pmu_pkg::ST_RD_GET_IDX: if (qry_arg_valid) state <= pmu_pkg::ST_RD_WR_ADDR;
				pmu_pkg::ST_RD_WR_ADDR, pmu_pkg::ST_RD_SUBADDR, pmu_pkg::ST_RD_RD_ADDR,
				pmu_pkg::ST_RD_DATA: begin
					if (i2c.failed)
						state <= pmu_pkg::ST_RD_REPLY;
					else if (i2c.data_latched)
						state <= pmu_pkg::ctrl_state_t'(state + 5'd1);
				end
				pmu_pkg::ST_RD_WR_DONE: begin
					if (i2c.failed)
						state <= pmu_pkg::ST_RD_REPLY;
					else if (i2c.ready)
						state <= pmu_pkg::ST_RD_RD_ADDR; // repeated start
				end
				pmu_pkg::ST_RD_DONE: begin
					if (i2c.failed || i2c.ready)
						state <= pmu_pkg::ST_RD_REPLY;
				end
				default: state <= pmu_pkg::ST_IDLE; // reply states last one cycle
			endcase
		end
	end
endmodule

`default_nettype wire

//--- hw/pmu_setting_regs.sv
`default_nettype none

module pmu_setting_regs (
	input wire logic clk,
	input wire logic reset,
	input wire logic latch_param,
	input wire logic latch_idx,
	input wire logic latch_val,
	input wire logic [7:0] arg_data,
	output logic [7:0] subaddr,
	output logic [7:0] wvalue,
	output logic is_volt,
	output logic [1:0] rail_idx
);
	logic [3:0] en_reg; // shadow of the chip enable bits
	logic [4:0] volt_code;
	logic [7:0] volt_subaddr;

	always_ff @(posedge clk) begin
		if (reset) begin
			is_volt <= 1'b0;
			rail_idx <= 2'd0;
			en_reg <= 4'd0;
		end else begin
			if (latch_param)
				is_volt <= (arg_data == pmu_pkg::PARAM_VOLT);
			if (latch_idx)
				rail_idx <= arg_data[1:0];
			if (latch_val && !is_volt)
				en_reg[rail_idx] <= arg_data[0];
		end
	end

	always_ff @(posedge clk) begin
		if (latch_val && is_volt)
			volt_code <= arg_data[4:0];
	end

	always_comb begin
		case (rail_idx)
			2'd0: volt_subaddr = pmu_pkg::VOLT_SUBADDR_0;
			2'd1: volt_subaddr = pmu_pkg::VOLT_SUBADDR_1;
			2'd2: volt_subaddr = pmu_pkg::VOLT_SUBADDR_2;
			default: volt_subaddr = pmu_pkg::VOLT_SUBADDR_3;
		endcase
	end

	assign subaddr = is_volt ? volt_subaddr : pmu_pkg::EN_SUBADDR;
	// enable register bit layout of the pmu
	assign wvalue = is_volt ? {3'b000, volt_code} :
		{3'b100, en_reg[0], 1'b1, en_reg[2], en_reg[1], en_reg[3]};
endmodule

`default_nettype wire

//--- hw/frame_header_decoder.sv
`default_nettype none

module frame_header_decoder #(
	parameter logic [7:0] match_addr = 8'h00
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic in_frame_valid,
	input wire logic in_data_valid,
	input wire logic [7:0] in_data,
	input wire logic header_done_clear,
	output logic header_done,
	output logic [7:0] header_eid,
	output logic arg_valid,
	output logic [7:0] arg_data
);
	logic [1:0] byte_cnt; // 0 address, 1 eid, 2 arguments
	logic matched;

	always_ff @(posedge clk) begin
		if (reset || !in_frame_valid) begin
			byte_cnt <= 2'd0;
			matched <= 1'b0;
			header_done <= 1'b0;
			arg_valid <= 1'b0;
		end else begin
			arg_valid <= in_data_valid && matched && (byte_cnt == 2'd2);
			if (header_done_clear)
				header_done <= 1'b0;
			if (in_data_valid) begin
				if (byte_cnt != 2'd2)
					byte_cnt <= byte_cnt + 2'd1;
				if (byte_cnt == 2'd0)
					matched <= (in_data == match_addr); // other frames dropped
				if (byte_cnt == 2'd1 && matched)
					header_done <= 1'b1; // wins over a clear
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_data_valid && byte_cnt == 2'd1)
			header_eid <= in_data;
		arg_data <= in_data;
	end
endmodule

`default_nettype wire

//--- hw/pmu_i2c_if.sv
`default_nettype none

interface pmu_i2c_if;
	logic start;
	logic done;
	logic rw; // 1 write, 0 read
	logic [7:0] wdata;
	logic clear_failed;
	logic data_latched;
	logic ready;
	logic failed;
	logic [7:0] rdata;
	logic rdata_valid;

	modport ctrl (output start, done, rw, wdata, clear_failed,
		input data_latched, ready, failed, rdata, rdata_valid);

	modport master (input start, done, rw, wdata,
		output data_latched, ready, failed, rdata, rdata_valid);
endinterface

`default_nettype wire

//--- hw/pmu_pkg.sv
`default_nettype none

package pmu_pkg;

	// bus service addresses
	localparam logic [7:0] SET_ADDR = 8'h70;
	localparam logic [7:0] QUERY_ADDR = 8'h50;
	localparam logic [7:0] PARAM_VOLT = 8'h76; // 'v'

	// pmu chip on the i2c bus
	localparam logic [7:0] PMU_WR_ADDR = 8'h68;
	localparam logic [7:0] PMU_RD_ADDR = 8'h69;
	localparam logic [7:0] EN_SUBADDR = 8'h10;
	localparam logic [7:0] VOLT_SUBADDR_0 = 8'h32;
	localparam logic [7:0] VOLT_SUBADDR_1 = 8'h26;
	localparam logic [7:0] VOLT_SUBADDR_2 = 8'h29;
	localparam logic [7:0] VOLT_SUBADDR_3 = 8'h23;

	localparam logic [15:0] I2C_QUARTER = 16'd4; // clk cycles per quarter scl

	typedef enum logic [7:0] {
		STATUS_ACK = 8'h00,
		STATUS_NAK = 8'h01
	} reply_status_t;

	typedef enum logic [4:0] {
		ST_IDLE, ST_GET_PARAM, ST_GET_IDX, ST_GET_VAL,
		ST_I2C_ADDR, ST_I2C_SUBADDR, ST_I2C_DATA, ST_I2C_DONE, ST_ACK,
		ST_RD_GET_PARAM, ST_RD_GET_IDX, ST_RD_WR_ADDR, ST_RD_SUBADDR,
		ST_RD_WR_DONE, ST_RD_RD_ADDR, ST_RD_DATA, ST_RD_DONE, ST_RD_REPLY
	} ctrl_state_t;

endpackage

`default_nettype wire
